/* verilog/buf_pkg.sv */
`default_nettype none

package buf_pkg;

   // host data width on the register port
   localparam int REG_W = 16;

   typedef enum logic [1:0] {
      REG_DATA   = 2'd0,
      REG_STATUS = 2'd1,
      REG_CTRL   = 2'd2,
      REG_CLEAR  = 2'd3
   } reg_addr_e;

   // one host access, strobes last a single cycle
   typedef struct packed {
      logic             wr;
      logic             rd;
      reg_addr_e        addr;
      logic [REG_W-1:0] wdata;
   } reg_req_t;

   typedef struct packed {
      logic push;
      logic pop;
   } fifo_ctl_t;

   // empty and full are levels, ovf and udf are pulses
   typedef struct packed {
      logic empty;
      logic full;
      logic ovf;
      logic udf;
   } fifo_flags_t;

endpackage

`default_nettype wire

/* verilog/dp_ram.sv */
`default_nettype none

module dp_ram #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 4
) (
   input  logic              clk,
   // write port
   input  logic              w_en,
   input  logic [ADDR_W-1:0] w_addr,
   input  logic [DATA_W-1:0] data_in,
   // read port
   input  logic              r_en,
   input  logic [ADDR_W-1:0] r_addr,
   output logic [DATA_W-1:0] data_out
);

   localparam int DEPTH = 1 << ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];

   always_ff @(posedge clk) begin
      if (w_en) begin
         mem[w_addr] <= data_in;
      end
   end

   // output register holds the last word read
   always_ff @(posedge clk) begin
      if (r_en) begin
         data_out <= mem[r_addr];
      end
   end

endmodule

`default_nettype wire

/* verilog/sync_fifo.sv */
`default_nettype none

module sync_fifo
   import buf_pkg::*;
#(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 4
) (
   input  logic              clk,
   input  logic              rst,
   input  fifo_ctl_t         ctl,
   input  logic [DATA_W-1:0] data_in,
   output logic [DATA_W-1:0] data_out,
   output fifo_flags_t       flags,
   output logic [ADDR_W:0]   occupancy
);

   localparam logic [ADDR_W:0] DEPTH = {1'b1, {ADDR_W{1'b0}}};

   logic              empty;
   logic              full;
   logic              push_int;
   logic              pop_int;
   logic [ADDR_W-1:0] wptr;
   logic [ADDR_W-1:0] rptr;

   // blocked accesses never reach the memory
   assign push_int = ctl.push & ~full;
   assign pop_int  = ctl.pop & ~empty;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wptr <= '0;
         rptr <= '0;
      end else begin
         if (push_int) begin
            wptr <= wptr + 1'b1;
         end
         if (pop_int) begin
            rptr <= rptr + 1'b1;
         end
      end
   end

   // count and flags move together, push and pop at once leaves them alone
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         occupancy <= '0;
         empty     <= 1'b1;
         full      <= 1'b0;
      end else if (push_int && !pop_int) begin
         occupancy <= occupancy + 1'b1;
         empty     <= 1'b0;
         if (occupancy == DEPTH - 1'b1) begin
            full <= 1'b1;
         end
      end else if (pop_int && !push_int) begin
         occupancy <= occupancy - 1'b1;
         full      <= 1'b0;
         if (occupancy == 1) begin
            empty <= 1'b1;
         end
      end
   end

   assign flags = '{empty: empty, full: full,
                    ovf: ctl.push & full, udf: ctl.pop & empty};

   dp_ram #(
      .DATA_W (DATA_W),
      .ADDR_W (ADDR_W)
   ) u_mem (
      .clk      (clk),
      .w_en     (push_int),
      .w_addr   (wptr),
      .data_in  (data_in),
      .r_en     (pop_int),
      .r_addr   (rptr),
      .data_out (data_out)
   );

endmodule

`default_nettype wire

/* verilog/fifo_regs.sv */
`default_nettype none

module fifo_regs
   import buf_pkg::*;
#(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 4
) (
   input  logic              clk,
   input  logic              rst,
   input  reg_req_t          req,
   input  logic [DATA_W-1:0] fifo_dout,
   input  fifo_flags_t       flags,
   input  logic [ADDR_W:0]   occupancy,
   output fifo_ctl_t         ctl,
   output logic [DATA_W-1:0] fifo_din,
   output logic [REG_W-1:0]  rdata,
   output logic              irq
);

   logic             wr_ctrl;
   logic             wr_clear;
   logic             rd_data;
   logic [4:0]       thresh;
   logic [2:0]       mask;
   logic             ovf_q;
   logic             udf_q;
   logic             level;
   logic             sel_fifo;
   logic [REG_W-1:0] status_word;
   logic [REG_W-1:0] ctrl_word;
   logic [REG_W-1:0] rd_word;
   logic [REG_W-1:0] reg_word;

   assign wr_ctrl  = req.wr && (req.addr == REG_CTRL);
   assign wr_clear = req.wr && (req.addr == REG_CLEAR);
   assign rd_data  = req.rd && (req.addr == REG_DATA);

   assign ctl.push = req.wr && (req.addr == REG_DATA);
   assign ctl.pop  = rd_data;
   assign fifo_din = req.wdata[DATA_W-1:0];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         thresh <= '0;
         mask   <= '0;
      end else if (wr_ctrl) begin
         thresh <= req.wdata[4:0];
         mask   <= req.wdata[10:8];
      end
   end

   // sticky errors, a clear bit sits at the same position as in STATUS
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ovf_q <= 1'b0;
         udf_q <= 1'b0;
      end else begin
         if (flags.ovf) begin
            ovf_q <= 1'b1;
         end else if (wr_clear && req.wdata[3]) begin
            ovf_q <= 1'b0;
         end
         if (flags.udf) begin
            udf_q <= 1'b1;
         end else if (wr_clear && req.wdata[4]) begin
            udf_q <= 1'b0;
         end
      end
   end

   assign level = (occupancy >= thresh);

   always_comb begin
      status_word = '0;
      status_word[0] = flags.empty;
      status_word[1] = flags.full;
      status_word[2] = level;
      status_word[3] = ovf_q;
      status_word[4] = udf_q;
      status_word[8 +: ADDR_W+1] = occupancy;
   end

   assign ctrl_word = {5'b0, mask, 3'b0, thresh};

   // data reads and reads of CLEAR give zero here
   always_comb begin
      case (req.addr)
         REG_STATUS: rd_word = status_word;
         REG_CTRL:   rd_word = ctrl_word;
         default:    rd_word = '0;
      endcase
   end

   // an empty pop falls back to the zero word
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         sel_fifo <= 1'b0;
         reg_word <= '0;
      end else if (req.rd) begin
         sel_fifo <= rd_data && !flags.empty;
         reg_word <= rd_word;
      end
   end

   assign rdata = sel_fifo ? REG_W'(fifo_dout) : reg_word;

   // mask order is level, ovf, udf
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         irq <= 1'b0;
      end else begin
         irq <= |(mask & {udf_q, ovf_q, level});
      end
   end

endmodule

`default_nettype wire

/* verilog/buf_top.sv */
`default_nettype none

module buf_top
   import buf_pkg::*;
#(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 4
) (
   input  logic             clk,
   input  logic             rst,
   input  reg_req_t         req,
   output logic [REG_W-1:0] rdata,
   output logic             irq
);

   fifo_ctl_t         ctl;
   fifo_flags_t       flags;
   logic [DATA_W-1:0] fifo_din;
   logic [DATA_W-1:0] fifo_dout;
   logic [ADDR_W:0]   occupancy;

   fifo_regs #(
      .DATA_W (DATA_W),
      .ADDR_W (ADDR_W)
   ) u_regs (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .fifo_dout (fifo_dout),
      .flags     (flags),
      .occupancy (occupancy),
      .ctl       (ctl),
      .fifo_din  (fifo_din),
      .rdata     (rdata),
      .irq       (irq)
   );

   sync_fifo #(
      .DATA_W (DATA_W),
      .ADDR_W (ADDR_W)
   ) u_fifo (
      .clk       (clk),
      .rst       (rst),
      .ctl       (ctl),
      .data_in   (fifo_din),
      .data_out  (fifo_dout),
      .flags     (flags),
      .occupancy (occupancy)
   );

endmodule

`default_nettype wire

/* dv/buf_checker.sv */
`default_nettype none

module buf_checker
   import buf_pkg::*;
#(
   parameter int ADDR_W = 4
) (
   input logic            clk,
   input logic            rst,
   input fifo_flags_t     flags,
   input logic [ADDR_W:0] occupancy,
   input logic [2:0]      mask,
   input logic            irq
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [ADDR_W:0] DEPTH = {1'b1, {ADDR_W{1'b0}}};

   flags_exclusive: assert property (@(posedge clk) disable iff (rst)
      !(flags.empty && flags.full))
      else $error("fifo empty and full are high together");

   occupancy_bound: assert property (@(posedge clk) disable iff (rst)
      occupancy <= DEPTH)
      else $error("fifo occupancy is above its depth");

   // blocked push only when the count says the fifo is full
   ovf_when_full: assert property (@(posedge clk) disable iff (rst)
      flags.ovf |-> (occupancy == DEPTH))
      else $error("overflow pulse while the fifo is not full");

   udf_when_empty: assert property (@(posedge clk) disable iff (rst)
      flags.udf |-> (occupancy == '0))
      else $error("underflow pulse while the fifo is not empty");

   // irq follows the mask one cycle later
   irq_masked: assert property (@(posedge clk) disable iff (rst)
      (mask == 3'b000) |=> !irq)
      else $error("irq is high with all mask bits clear");

endmodule

// fifo_regs sees the fifo flags, the occupancy, the mask and irq
bind fifo_regs buf_checker #(.ADDR_W(ADDR_W)) chk (
   .clk       (clk),
   .rst       (rst),
   .flags     (flags),
   .occupancy (occupancy),
   .mask      (mask),
   .irq       (irq)
);

`default_nettype wire

/* dv/buf_tb.sv */
`default_nettype none

module buf_tb
   import buf_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int DEPTH = 16;

   logic             clk;
   logic             rst;
   reg_req_t         req;
   logic [REG_W-1:0] rdata;
   logic             irq;

   // reference model state
   logic [7:0]  model_q[$];
   logic        ovf_m;
   logic        udf_m;
   int          thresh_m;
   logic [31:0] rng_state;
   int          checks;
   int          errors;

   buf_top dut (
      .clk   (clk),
      .rst   (rst),
      .req   (req),
      .rdata (rdata),
      .irq   (irq)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift(rng_state);
      return rng_state;
   endfunction

   // STATUS as the model predicts it
   function automatic logic [15:0] expected_status();
      logic [15:0] w;
      int          n;
      n = model_q.size();
      w = '0;
      w[0] = (n == 0);
      w[1] = (n == DEPTH);
      w[2] = (n >= thresh_m);
      w[3] = ovf_m;
      w[4] = udf_m;
      w[12:8] = n[4:0];
      return w;
   endfunction

   task automatic check_eq(input logic [15:0] got, input logic [15:0] exp, input string what);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic bus_write(input reg_addr_e addr, input logic [15:0] data);
      req.wr    = 1'b1;
      req.rd    = 1'b0;
      req.addr  = addr;
      req.wdata = data;
      @(posedge clk);
      #1;
      req = '0;
   endtask

   // rdata is registered at the edge that takes the strobe
   task automatic bus_read(input reg_addr_e addr, output logic [15:0] data);
      req.wr    = 1'b0;
      req.rd    = 1'b1;
      req.addr  = addr;
      req.wdata = '0;
      @(posedge clk);
      #1;
      req  = '0;
      data = rdata;
   endtask

   task automatic push_word(input logic [7:0] d);
      bus_write(REG_DATA, {8'h00, d});
      if (model_q.size() < DEPTH) begin
         model_q.push_back(d);
      end else begin
         ovf_m = 1'b1;
      end
   endtask

   task automatic pop_word();
      logic [15:0] got;
      logic [15:0] exp;
      bus_read(REG_DATA, got);
      if (model_q.size() == 0) begin
         exp   = '0;
         udf_m = 1'b1;
      end else begin
         exp = {8'h00, model_q.pop_front()};
      end
      check_eq(got, exp, "popped word");
   endtask

   task automatic check_status(input string what);
      logic [15:0] got;
      bus_read(REG_STATUS, got);
      check_eq(got, expected_status(), what);
   endtask

   task automatic clear_flags();
      bus_write(REG_CLEAR, 16'h0018);
      ovf_m = 1'b0;
      udf_m = 1'b0;
   endtask

   task automatic wait_irq(input logic level, input int max_cycles, input string what);
      int n;
      n = 0;
      while (irq !== level && n < max_cycles) begin
         @(posedge clk);
         #1;
         n++;
      end
      checks++;
      assert (irq === level) else begin
         errors++;
         $display("timeout at %0t ns: irq did not go to %0b %s", $time, level, what);
      end
   endtask

   task automatic report_test(input string name, input int err_start);
      $display("%s: %s, %0d errors", name, (errors == err_start) ? "ok" : "failed",
               errors - err_start);
   endtask

   task automatic test_reset();
      int e;
      e = errors;
      check_status("status after reset");
      check_eq({15'b0, irq}, 16'h0000, "irq after reset");
      report_test("reset", e);
   endtask

   task automatic test_in_order();
      int          e;
      logic [31:0] r;
      e = errors;
      for (int i = 0; i < 10; i++) begin
         r = next_random();
         push_word(r[7:0]);
         check_status("status after push");
      end
      for (int i = 0; i < 10; i++) begin
         pop_word();
         check_status("status after pop");
      end
      report_test("in_order", e);
   endtask

   task automatic test_full();
      int          e;
      logic [31:0] r;
      e = errors;
      for (int i = 0; i < DEPTH + 1; i++) begin
         r = next_random();
         push_word(r[7:0]);
      end
      check_status("status after overflow");
      for (int i = 0; i < DEPTH; i++) begin
         pop_word();
      end
      check_status("status after draining a full fifo");
      report_test("full", e);
   endtask

   task automatic test_underflow();
      int e;
      e = errors;
      pop_word();
      check_status("status after underflow");
      clear_flags();
      check_status("status after clear");
      report_test("underflow", e);
   endtask

   task automatic test_irq();
      int          e;
      logic [31:0] r;
      logic [15:0] got;
      e = errors;
      // threshold 5, level mask only
      bus_write(REG_CTRL, 16'h0105);
      thresh_m = 5;
      bus_read(REG_CTRL, got);
      check_eq(got, 16'h0105, "ctrl readback");
      for (int i = 0; i < 4; i++) begin
         r = next_random();
         push_word(r[7:0]);
      end
      check_status("status below threshold");
      check_eq({15'b0, irq}, 16'h0000, "irq below threshold");
      r = next_random();
      push_word(r[7:0]);
      wait_irq(1'b1, 8, "after the fifth push");
      pop_word();
      wait_irq(1'b0, 8, "after a pop below threshold");
      bus_write(REG_CTRL, 16'h0000);
      thresh_m = 0;
      while (model_q.size() > 0) begin
         pop_word();
      end
      check_status("status after irq test");
      report_test("irq", e);
   endtask

   task automatic test_mixed();
      int          e;
      logic [31:0] r;
      logic        do_push;
      e = errors;
      clear_flags();
      for (int i = 0; i < 200; i++) begin
         r = next_random();
         // lean towards pushes while the fifo is low
         if (model_q.size() <= 8) begin
            do_push = (r[9:8] != 2'd0);
         end else begin
            do_push = (r[9:8] == 2'd3);
         end
         if (do_push) begin
            push_word(r[7:0]);
         end else begin
            pop_word();
         end
         check_status("status in mixed sequence");
      end
      report_test("mixed", e);
   endtask

   // safety limit on the whole run
   initial begin
      #200000;
      $display("timeout: the simulation did not finish in time");
      $display("Finished with errors");
      $finish;
   end

   initial begin
      req       = '0;
      rst       = 1'b1;
      ovf_m     = 1'b0;
      udf_m     = 1'b0;
      thresh_m  = 0;
      rng_state = 32'd14210;
      checks    = 0;
      errors    = 0;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;

      test_reset();
      test_in_order();
      test_full();
      test_underflow();
      test_irq();
      test_mixed();

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* buf_fifo.f */
verilog/buf_pkg.sv
verilog/dp_ram.sv
verilog/sync_fifo.sv
verilog/fifo_regs.sv
verilog/buf_top.sv
dv/buf_checker.sv
dv/buf_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = buf_tb
FLIST     = buf_fifo.f
OBJ_DIR   = obj_dir
PASS_MSG  = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
